//--- compile.f
+incdir+.
dec_pkg.sv
instr_decoder.sv
operand_forward.sv
branch_resolver.sv
issue_queue.sv
dec_stage.sv
dec_assert.sv
tb_clk_gen.sv
tb_dec.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module tb_dec -o tb_dec &&
./obj_dir/tb_dec || exit 1

//--- tb_dec.sv
`timescale 1ns/10ps
`include "dec_settings.svh"

module tb_dec
    import dec_pkg::*;
();

    localparam int INSTR_COUNT = 2000;
    localparam int IDLE_LIMIT  = 400;

    logic       clk;
    logic       reset_n;
    instr_u     instr;
    word_t      pc;
    logic       in_empty;
    logic       in_pop;
    reg_adr_t   rs1_adr;
    reg_adr_t   rs2_adr;
    word_t      rs1_data;
    word_t      rs2_data;
    fwd_src_t   fwd_exe;
    fwd_src_t   fwd_mem;
    issue_pkt_t out_pkt;
    logic       out_empty;
    logic       out_pop;
    redirect_t  redirect;

    word_t      regs [32];
    issue_pkt_t exp_q [$];
    integer     seed;

    tb_clk_gen u_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    dec_stage DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .instr     (instr),
        .pc        (pc),
        .in_empty  (in_empty),
        .in_pop    (in_pop),
        .rs1_adr   (rs1_adr),
        .rs2_adr   (rs2_adr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .fwd_exe   (fwd_exe),
        .fwd_mem   (fwd_mem),
        .out_pkt   (out_pkt),
        .out_empty (out_empty),
        .out_pop   (out_pop),
        .redirect  (redirect)
    );

    // Register file reads, x0 stays zero
    assign rs1_data = regs[rs1_adr];
    assign rs2_data = regs[rs2_adr];

    // ----------------------------------------------------------------------
    // Error handling and compares
    // ----------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_pkt(input issue_pkt_t got, input issue_pkt_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: out_pkt got %h expected %h",
                                $time, got, exp));
    endtask

    task automatic compare_redirect(input redirect_t got, input redirect_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target))
            abort_run($sformatf("mismatch at %0t: redirect got %h expected %h",
                                $time, got, exp));
    endtask

    task automatic compare_stall(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: in_pop got %b expected %b",
                                $time, got, exp));
    endtask

    task automatic compare_empty(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: out_empty got %b expected %b",
                                $time, got, exp));
    endtask

    task automatic compare_adr(input string name, input reg_adr_t got, input reg_adr_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
    endtask

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic word_t rnd();
        return word_t'($random(seed));
    endfunction

    function automatic alu_op_e alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Youngest non-load producer first, then memory, then the register file
    function automatic word_t fwd_value(input reg_adr_t adr);
        if (adr == '0)
            return '0;
        if (fwd_exe.valid && fwd_exe.dest == adr && !fwd_exe.is_load)
            return fwd_exe.result;
        if (fwd_mem.valid && fwd_mem.dest == adr)
            return fwd_mem.result;
        return regs[adr];
    endfunction

    function automatic logic hazard_on(input reg_adr_t adr, input logic used);
        logic hit;
        hit = fwd_exe.valid && fwd_exe.is_load && fwd_exe.dest == adr;
        foreach (exp_q[i])
            if (exp_q[i].wb && exp_q[i].rd == adr)
                hit = 1'b1;
        return used && adr != '0 && hit;
    endfunction

    task automatic model_decode(input word_t w, input word_t pc_v, output issue_pkt_t p,
                                output redirect_t r, output logic [1:0] uses);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        logic       ok;
        logic       taken;
        f3    = w[14:12];
        f7    = w[31:25];
        a     = fwd_value(w[19:15]);
        b     = fwd_value(w[24:20]);
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        p     = '0;
        r     = '0;
        uses  = 2'b00;
        ok    = 1'b1;
        taken = 1'b0;
        p.pc  = pc_v;
        p.wb  = 1'b1;
        case (w[6:0])
            7'b0110011: begin
                uses     = 2'b11;
                p.op1    = a;
                p.op2    = b;
                p.alu_op = alu_code(f3, f7[5]);
                ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            7'b0010011: begin
                uses     = 2'b01;
                p.op1    = a;
                p.op2    = imm_i;
                p.alu_op = alu_code(f3, f3 == 3'd5 && w[30]);
                if (f3 == 3'd1)
                    ok = f7 == 7'h00;
                if (f3 == 3'd5)
                    ok = f7 == 7'h00 || f7 == 7'h20;
            end
            7'b0110111: p.op2 = {w[31:12], 12'h000};
            7'b0010111: begin
                p.op1 = pc_v;
                p.op2 = {w[31:12], 12'h000};
            end
            7'b0000011: begin
                uses         = 2'b01;
                p.op1        = a;
                p.op2        = imm_i;
                p.load       = 1'b1;
                p.mem_size   = mem_size_e'(f3[1:0]);
                p.mem_signed = !f3[2];
                ok = f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
            end
            7'b0100011: begin
                uses         = 2'b11;
                p.wb         = 1'b0;
                p.op1        = a;
                p.op2        = {{20{w[31]}}, w[31:25], w[11:7]};
                p.store      = 1'b1;
                p.mem_size   = mem_size_e'(f3[1:0]);
                p.store_data = b;
                ok = f3 <= 3'd2;
            end
            7'b1100011: begin
                uses  = 2'b11;
                p.wb  = 1'b0;
                p.op2 = imm_b;
                case (f3)
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                r.valid  = taken;
                r.target = pc_v + imm_b;
                ok = f3 != 3'd2 && f3 != 3'd3;
            end
            7'b1101111: begin
                p.op1    = pc_v + 32'd4;
                r.valid  = 1'b1;
                r.target = pc_v + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111: begin
                uses     = 2'b01;
                p.op1    = pc_v + 32'd4;
                r.valid  = 1'b1;
                r.target = (a + imm_i) & ~32'd1;
                ok = f3 == 3'd0;
            end
            default: ok = 1'b0;
        endcase
        if (p.wb)
            p.rd = w[11:7];
        // Unknown words go out with only the flag and the pc
        if (!ok) begin
            p         = '0;
            p.pc      = pc_v;
            p.illegal = 1'b1;
            r         = '0;
            uses      = 2'b00;
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    function automatic word_t make_instr();
        word_t w;
        int    sel;
        w   = rnd();
        sel = int'(rnd() % 32'd20);
        if (sel != 0) begin
            if (sel <= 3 || sel == 19)
                w[6:0] = 7'b0110011;
            else if (sel <= 6)
                w[6:0] = 7'b0010011;
            else if (sel == 7)
                w[6:0] = 7'b0110111;
            else if (sel == 8)
                w[6:0] = 7'b0010111;
            else if (sel <= 11)
                w[6:0] = 7'b0000011;
            else if (sel <= 13)
                w[6:0] = 7'b0100011;
            else if (sel <= 16)
                w[6:0] = 7'b1100011;
            else if (sel == 17)
                w[6:0] = 7'b1101111;
            else
                w[6:0] = 7'b1100111;
            // Few registers, so producers and consumers meet often
            w[11:10] = 2'b00;
            w[19:18] = 2'b00;
            w[24:23] = 2'b00;
            if (w[6:0] == 7'b0110011 || (w[6:0] == 7'b0010011 && w[13:12] == 2'b01))
                w[31:25] = w[31] ? 7'h20 : 7'h00;
            if (w[6:0] == 7'b1100111 && !w[29])
                w[14:12] = 3'd0;
        end
        return w;
    endfunction

    task automatic drive_forwarding();
        fwd_exe.valid   = (rnd() % 32'd2) == 32'd0;
        fwd_exe.dest    = reg_adr_t'(rnd() % 32'd8);
        fwd_exe.is_load = (rnd() % 32'd4) == 32'd0;
        fwd_exe.result  = rnd();
        fwd_mem.valid   = (rnd() % 32'd2) == 32'd0;
        fwd_mem.dest    = reg_adr_t'(rnd() % 32'd8);
        fwd_mem.is_load = (rnd() % 32'd4) == 32'd0;
        fwd_mem.result  = rnd();
    endtask

    initial begin
        word_t      cur_word;
        word_t      fetch_pc;
        logic       have;
        issue_pkt_t exp_pkt;
        redirect_t  exp_red;
        logic [1:0] uses;
        logic       exp_pop;
        int         issued;
        int         cycles;
        int         idle;
        int         waited;
        seed     = 34;
        instr    = '0;
        pc       = '0;
        in_empty = 1'b1;
        fwd_exe  = '0;
        fwd_mem  = '0;
        out_pop  = 1'b0;
        for (int i = 0; i < 32; i++)
            regs[i] = (i == 0) ? '0 : rnd();
        cur_word = '0;
        fetch_pc = 32'h0000_1000;
        have     = 1'b0;
        issued   = 0;
        cycles   = 0;
        idle     = 0;
        waited   = 0;

        @(posedge clk);
        while (!reset_n) begin
            waited++;
            if (waited > 10)
                abort_run("timeout: reset was never released");
            @(posedge clk);
        end

        while (issued < INSTR_COUNT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!have && (rnd() % 32'd8) != 32'd0) begin
                cur_word = make_instr();
                have     = 1'b1;
            end
            instr    = cur_word;
            pc       = fetch_pc;
            in_empty = !have;
            drive_forwarding();
            // Alternate busy and slow execute phases
            if (((cycles / 300) % 2) == 1)
                out_pop = (rnd() % 32'd8) == 32'd0;
            else
                out_pop = (rnd() % 32'd4) != 32'd0;
            #5;
            model_decode(cur_word, fetch_pc, exp_pkt, exp_red, uses);
            exp_pop = have && !(hazard_on(cur_word[19:15], uses[0]) ||
                                hazard_on(cur_word[24:20], uses[1]) ||
                                exp_q.size() == `DEC_IQ_DEPTH);
            exp_red.valid = exp_red.valid && exp_pop;
            compare_adr("rs1_adr", rs1_adr, cur_word[19:15]);
            compare_adr("rs2_adr", rs2_adr, cur_word[24:20]);
            compare_stall(in_pop, exp_pop);
            compare_redirect(redirect, exp_red);
            compare_empty(out_empty, exp_q.size() == 0);
            if (out_pop && exp_q.size() != 0) begin
                compare_pkt(out_pkt, exp_q[0]);
                exp_q.delete(0);
            end
            if (exp_pop) begin
                exp_q.push_back(exp_pkt);
                fetch_pc = exp_red.valid ? exp_red.target : fetch_pc + 32'd4;
                have     = 1'b0;
                issued++;
                idle = 0;
            end else if (have) begin
                idle++;
            end
            if (idle > IDLE_LIMIT)
                abort_run("timeout: presented instruction was not taken in time");
            if (cycles > 50 * INSTR_COUNT)
                abort_run("timeout: not all instructions were issued");
        end

        // Drain what is left in the queue
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            in_empty = 1'b1;
            out_pop  = 1'b1;
            fwd_exe  = '0;
            fwd_mem  = '0;
            #5;
            compare_stall(in_pop, 1'b0);
            compare_empty(out_empty, 1'b0);
            compare_pkt(out_pkt, exp_q[0]);
            exp_q.delete(0);
            waited++;
            if (waited > 2 * `DEC_IQ_DEPTH)
                abort_run("timeout: issue queue did not drain");
        end
        @(posedge clk);
        #1;
        out_pop = 1'b0;
        #5;
        compare_empty(out_empty, 1'b1);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic reset_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset low for three rising edges
    initial begin
        reset_n = 1'b1;
        #1 reset_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

//--- dec_assert.sv
`timescale 1ns/10ps

module dec_assert (
    input logic clk,
    input logic reset_n,
    input logic in_empty,
    input logic in_pop,
    input logic out_empty,
    input logic redirect_valid
);

    // Fetch side handshake
    a_pop_needs_data: assert property (
        @(posedge clk) disable iff (!reset_n) in_empty |-> !in_pop
    ) else $error("in_pop high while in_empty is high");

    a_empty_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> out_empty
    ) else $error("issue queue not empty after reset");

    // A redirect only comes with a consumed instruction
    a_redirect_with_pop: assert property (
        @(posedge clk) disable iff (!reset_n) redirect_valid |-> in_pop
    ) else $error("redirect valid without an instruction pop");

endmodule

bind dec_stage dec_assert u_assert (
    .clk            (clk),
    .reset_n        (reset_n),
    .in_empty       (in_empty),
    .in_pop         (in_pop),
    .out_empty      (out_empty),
    .redirect_valid (redirect.valid)
);

//--- dec_stage.sv
`timescale 1ns/10ps
`include "dec_settings.svh"

module dec_stage
    import dec_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  instr_u     instr,
    input  word_t      pc,
    input  logic       in_empty,
    output logic       in_pop,
    output reg_adr_t   rs1_adr,
    output reg_adr_t   rs2_adr,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    input  fwd_src_t   fwd_exe,
    input  fwd_src_t   fwd_mem,
    output issue_pkt_t out_pkt,
    output logic       out_empty,
    input  logic       out_pop,
    output redirect_t  redirect
);

    dec_ctrl_t                ctrl;
    reg_adr_t                 rs_adr [2];
    logic [1:0]               rs_used;
    word_t                    reg_data [2];
    word_t                    fwd_data [2];
    logic [1:0]               hazard;
    issue_pkt_t               pkt;
    logic                     push;
    logic                     queue_full;
    reg_adr_t                 pending_dest [`DEC_IQ_DEPTH];
    logic [`DEC_IQ_DEPTH-1:0] pending_valid;

    assign rs1_adr     = rs_adr[0];
    assign rs2_adr     = rs_adr[1];
    assign reg_data[0] = rs1_data;
    assign reg_data[1] = rs2_data;

    instr_decoder u_decoder (
        .instr   (instr),
        .ctrl    (ctrl),
        .rs_adr  (rs_adr),
        .rs_used (rs_used)
    );

    // One forwarding unit per source operand
    genvar g;
    generate
        for (g = 0; g < 2; g++) begin : g_fwd
            operand_forward u_fwd (
                .adr           (rs_adr[g]),
                .used          (rs_used[g]),
                .reg_data      (reg_data[g]),
                .fwd_exe       (fwd_exe),
                .fwd_mem       (fwd_mem),
                .pending_dest  (pending_dest),
                .pending_valid (pending_valid),
                .data          (fwd_data[g]),
                .hazard        (hazard[g])
            );
        end
    endgenerate

    branch_resolver u_resolver (
        .ctrl       (ctrl),
        .pc         (pc),
        .rs_data    (fwd_data),
        .hazard     (hazard),
        .in_empty   (in_empty),
        .queue_full (queue_full),
        .push       (push),
        .in_pop     (in_pop),
        .pkt        (pkt),
        .redirect   (redirect)
    );

    issue_queue #(
        .DEPTH (`DEC_IQ_DEPTH)
    ) u_queue (
        .clk           (clk),
        .reset_n       (reset_n),
        .push          (push),
        .pkt_in        (pkt),
        .pop           (out_pop),
        .pkt_out       (out_pkt),
        .empty         (out_empty),
        .full          (queue_full),
        .pending_dest  (pending_dest),
        .pending_valid (pending_valid)
    );

endmodule

//--- issue_queue.sv
`timescale 1ns/10ps
`include "dec_settings.svh"

module issue_queue
    import dec_pkg::*;
#(
    parameter int DEPTH = `DEC_IQ_DEPTH
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             push,
    input  issue_pkt_t       pkt_in,
    input  logic             pop,
    output issue_pkt_t       pkt_out,
    output logic             empty,
    output logic             full,
    output reg_adr_t         pending_dest [DEPTH],
    output logic [DEPTH-1:0] pending_valid
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    issue_pkt_t    mem [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] cnt;
    logic          do_push;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = cnt == '0;
    assign full    = cnt == CW'(DEPTH);
    assign do_pop  = pop && !empty;
    // A slot frees up when the head leaves this cycle
    assign do_push = push && (!full || do_pop);
    assign pkt_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= pkt_in;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            cnt <= cnt + CW'(do_push) - CW'(do_pop);
        end
    end

    // Destinations of entries not yet taken by execute
    always_comb begin
        int off;
        for (int i = 0; i < DEPTH; i++) begin
            off = i - int'(rd_ptr);
            if (off < 0)
                off = off + DEPTH;
            pending_dest[i]  = mem[i].rd;
            pending_valid[i] = (off < int'(cnt)) && mem[i].wb && mem[i].rd != '0;
        end
    end

endmodule

//--- branch_resolver.sv
`timescale 1ns/10ps
`include "dec_settings.svh"

module branch_resolver
    import dec_pkg::*;
(
    input  dec_ctrl_t  ctrl,
    input  word_t      pc,
    input  word_t      rs_data [2],
    input  logic [1:0] hazard,
    input  logic       in_empty,
    input  logic       queue_full,
    output logic       push,
    output logic       in_pop,
    output issue_pkt_t pkt,
    output redirect_t  redirect
);

    word_t link;
    word_t jalr_sum;
    logic  taken;
    logic  jump;
    logic  stall;

    assign link = pc + word_t'(`DEC_PC_INC);

    // ----------------------------------------------------------------------
    // Branch condition and targets
    // ----------------------------------------------------------------------
    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   taken = rs_data[0] == rs_data[1];
            BR_NE:   taken = rs_data[0] != rs_data[1];
            BR_LT:   taken = $signed(rs_data[0]) < $signed(rs_data[1]);
            BR_GE:   taken = $signed(rs_data[0]) >= $signed(rs_data[1]);
            BR_LTU:  taken = rs_data[0] < rs_data[1];
            default: taken = rs_data[0] >= rs_data[1];
        endcase
    end

    assign jump     = ctrl.jal || ctrl.jalr || (ctrl.branch && taken);
    assign jalr_sum = rs_data[0] + ctrl.imm;

    // ----------------------------------------------------------------------
    // Issue control
    // ----------------------------------------------------------------------
    assign stall  = |hazard || queue_full;
    assign in_pop = !in_empty && !stall;
    assign push   = in_pop;

    assign redirect.valid  = in_pop && jump;
    assign redirect.target = ctrl.jalr ? {jalr_sum[`DEC_XLEN-1:1], 1'b0} : pc + ctrl.imm;

    always_comb begin
        pkt.pc = pc;
        if (ctrl.alu || ctrl.alu_imm || ctrl.load || ctrl.store)
            pkt.op1 = rs_data[0];
        else if (ctrl.auipc)
            pkt.op1 = pc;
        else if (ctrl.jal || ctrl.jalr)
            pkt.op1 = link;
        else
            pkt.op1 = '0;
        if (ctrl.alu)
            pkt.op2 = rs_data[1];
        else if (ctrl.jal || ctrl.jalr)
            pkt.op2 = '0;
        else
            pkt.op2 = ctrl.imm;
        pkt.alu_op     = ctrl.alu_op;
        pkt.rd         = ctrl.rd;
        pkt.wb         = ctrl.wb;
        pkt.load       = ctrl.load;
        pkt.store      = ctrl.store;
        pkt.mem_size   = ctrl.mem_size;
        pkt.mem_signed = ctrl.mem_signed;
        pkt.store_data = ctrl.store ? rs_data[1] : '0;
        pkt.illegal    = ctrl.illegal;
    end

endmodule

//--- operand_forward.sv
`timescale 1ns/10ps
`include "dec_settings.svh"

module operand_forward
    import dec_pkg::*;
(
    input  reg_adr_t                 adr,
    input  logic                     used,
    input  word_t                    reg_data,
    input  fwd_src_t                 fwd_exe,
    input  fwd_src_t                 fwd_mem,
    input  reg_adr_t                 pending_dest [`DEC_IQ_DEPTH],
    input  logic [`DEC_IQ_DEPTH-1:0] pending_valid,
    output word_t                    data,
    output logic                     hazard
);

    logic nonzero;
    logic exe_hit;
    logic mem_hit;
    logic queue_hit;

    assign nonzero = adr != '0;
    assign exe_hit = nonzero && fwd_exe.valid && fwd_exe.dest == adr;
    assign mem_hit = nonzero && fwd_mem.valid && fwd_mem.dest == adr;

    // Writer still waiting in the issue queue
    always_comb begin
        queue_hit = 1'b0;
        for (int i = 0; i < `DEC_IQ_DEPTH; i++) begin
            if (pending_valid[i] && pending_dest[i] == adr)
                queue_hit = 1'b1;
        end
    end

    // Youngest producer wins
    always_comb begin
        if (!nonzero)
            data = '0;
        else if (exe_hit && !fwd_exe.is_load)
            data = fwd_exe.result;
        else if (mem_hit)
            data = fwd_mem.result;
        else
            data = reg_data;
    end

    // Load data is not ready until the memory stage
    assign hazard = used && ((exe_hit && fwd_exe.is_load) || (nonzero && queue_hit));

endmodule

//--- instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder
    import dec_pkg::*;
(
    input  instr_u     instr,
    output dec_ctrl_t  ctrl,
    output reg_adr_t   rs_adr [2],
    output logic [1:0] rs_used
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Sign-extended immediates
    // ----------------------------------------------------------------------
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'h000};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    // Register file is addressed straight from the word
    assign rs_adr[0] = instr.r.rs1;
    assign rs_adr[1] = instr.r.rs2;
    assign rs_used   = {ctrl.uses_rs2, ctrl.uses_rs1};

    always_comb begin
        logic [2:0] f3;
        logic ok;
        f3 = instr.r.funct3;
        ok = 1'b1;
        ctrl = '0;
        ctrl.rd = instr.r.rd;
        case (instr.r.opcode)
            OPC_OP: begin
                ctrl.alu = 1'b1;
                ctrl.uses_rs1 = 1'b1;
                ctrl.uses_rs2 = 1'b1;
                ctrl.wb = 1'b1;
                ctrl.alu_op = alu_from_f3(f3, instr.r.funct7[5]);
                ok = (instr.r.funct7 == 7'h00) ||
                     (instr.r.funct7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            end
            OPC_OP_IMM: begin
                ctrl.alu_imm = 1'b1;
                ctrl.uses_rs1 = 1'b1;
                ctrl.wb = 1'b1;
                ctrl.imm = imm_i;
                ctrl.alu_op = alu_from_f3(f3, f3 == 3'b101 && instr.i.imm[10]);
                // Shift amounts only, upper bits select srl or sra
                if (f3 == 3'b001)
                    ok = instr.i.imm[11:5] == 7'h00;
                else if (f3 == 3'b101)
                    ok = instr.i.imm[11:5] == 7'h00 || instr.i.imm[11:5] == 7'h20;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.lui = instr.u.opcode == OPC_LUI;
                ctrl.auipc = instr.u.opcode == OPC_AUIPC;
                ctrl.wb = 1'b1;
                ctrl.imm = imm_u;
            end
            OPC_LOAD: begin
                ctrl.load = 1'b1;
                ctrl.uses_rs1 = 1'b1;
                ctrl.wb = 1'b1;
                ctrl.imm = imm_i;
                ctrl.mem_size = mem_size_e'(f3[1:0]);
                ctrl.mem_signed = !f3[2];
                ok = f3[1:0] != 2'b11 && f3 != 3'b110;
            end
            OPC_STORE: begin
                ctrl.store = 1'b1;
                ctrl.uses_rs1 = 1'b1;
                ctrl.uses_rs2 = 1'b1;
                ctrl.imm = imm_s;
                ctrl.mem_size = mem_size_e'(f3[1:0]);
                ok = !f3[2] && f3[1:0] != 2'b11;
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.uses_rs1 = 1'b1;
                ctrl.uses_rs2 = 1'b1;
                ctrl.imm = imm_b;
                ctrl.br_cond = br_cond_e'(f3);
                ok = f3[2:1] != 2'b01;
            end
            OPC_JAL: begin
                ctrl.jal = 1'b1;
                ctrl.wb = 1'b1;
                ctrl.imm = imm_j;
            end
            OPC_JALR: begin
                ctrl.jalr = 1'b1;
                ctrl.uses_rs1 = 1'b1;
                ctrl.wb = 1'b1;
                ctrl.imm = imm_i;
                ok = f3 == 3'b000;
            end
            default: ok = 1'b0;
        endcase

        // Unknown patterns still issue, with nothing but the flag
        if (!ok) begin
            ctrl = '0;
            ctrl.illegal = 1'b1;
        end else if (!ctrl.wb) begin
            ctrl.rd = '0;
        end
    end

endmodule

//--- dec_pkg.sv
`include "dec_settings.svh"

package dec_pkg;

    typedef logic [`DEC_XLEN-1:0] word_t;
    typedef logic [`DEC_REG_AW-1:0] reg_adr_t;

    // ----------------------------------------------------------------------
    // Instruction formats
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_adr_t   rs2;
        reg_adr_t   rs1;
        logic [2:0] funct3;
        reg_adr_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_adr_t    rs1;
        logic [2:0]  funct3;
        reg_adr_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_adr_t   rs2;
        reg_adr_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_adr_t   rs2;
        reg_adr_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_adr_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_adr_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word, read through whichever format applies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // Same encoding as the branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    // ----------------------------------------------------------------------
    // Stage payloads
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic      alu;
        logic      alu_imm;
        logic      lui;
        logic      auipc;
        logic      load;
        logic      store;
        logic      branch;
        logic      jal;
        logic      jalr;
        logic      illegal;
        logic      uses_rs1;
        logic      uses_rs2;
        reg_adr_t  rd;
        logic      wb;
        alu_op_e   alu_op;
        br_cond_e  br_cond;
        mem_size_e mem_size;
        logic      mem_signed;
        word_t     imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic     valid;
        reg_adr_t dest;
        logic     is_load;
        word_t    result;
    } fwd_src_t;

    typedef struct packed {
        word_t     pc;
        word_t     op1;
        word_t     op2;
        alu_op_e   alu_op;
        reg_adr_t  rd;
        logic      wb;
        logic      load;
        logic      store;
        mem_size_e mem_size;
        logic      mem_signed;
        word_t     store_data;
        logic      illegal;
    } issue_pkt_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

//--- dec_settings.svh
`ifndef DEC_SETTINGS_SVH
`define DEC_SETTINGS_SVH

// ----------------------------------------------------------------------
// Decode stage build settings
// ----------------------------------------------------------------------

// Data and PC width
`define DEC_XLEN 32

// Register file address width
`define DEC_REG_AW 5

// Entries in the decode to execute queue
`define DEC_IQ_DEPTH 4

// Sequential PC step
`define DEC_PC_INC 4

`endif
